// File: flist.f
+incdir+src
src/core_mem_pkg.sv
src/host_mem_pkg.sv
src/core_req_ctrl.sv
src/mem_word_array.sv
src/host_load_port.sv
src/global_mem_top.sv
tb/clk_rst_gen.sv
tb/global_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the global memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module global_mem_tb \
    -o global_mem_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/global_mem_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

# the log decides the result
grep -q "Regression failed" sim.log && exit 1 || exit 0

// File: tb/global_mem_tb.sv
/*
 * table driven testbench for the global memory top
 * host load and readback, core latency, aliasing, busy requests, write collision
 */
`timescale 1ns/1ps
`include "gpu_mem_consts.svh"

module global_mem_tb
    import core_mem_pkg::*;
    import host_mem_pkg::*;
();

    // entry kinds
    localparam logic [2:0] K_SET   = 3'd0;
    localparam logic [2:0] K_LOAD  = 3'd1;
    localparam logic [2:0] K_HREAD = 3'd2;
    localparam logic [2:0] K_CRD   = 3'd3;
    localparam logic [2:0] K_CWR   = 3'd4;
    // core read with an extra write issued while busy
    localparam logic [2:0] K_CBUSY = 3'd5;
    // core write with a host load_word in the strobe cycle
    localparam logic [2:0] K_COLL  = 3'd6;

    // longest wait for any response, in cycles
    localparam int WAIT_MAX = `GM_MEM_DELAY + 20;

    // alt is the second data word, exp the expected read value
    typedef struct packed {
        logic [2:0]                kind;
        logic [`GM_ADDR_WIDTH-1:0] addr;
        logic [`GM_DATA_WIDTH-1:0] data;
        logic [`GM_DATA_WIDTH-1:0] alt;
        logic [`GM_DATA_WIDTH-1:0] exp;
    } entry_t;

    logic                      clk;
    logic                      rst;
    core_req_t                 core_req;
    logic                      core_busy;
    logic                      core_ack;
    logic [`GM_DATA_WIDTH-1:0] core_rd_data;
    host_req_t                 host_req;
    logic [`GM_DATA_WIDTH-1:0] host_rd_data;
    logic                      host_rd_valid;

    entry_t                    tbl [$];
    // reference memory and host pointer
    logic [`GM_DATA_WIDTH-1:0] model [0:`GM_MEM_WORDS-1];
    logic [`GM_ADDR_WIDTH-1:0] mptr;
    integer                    seed;
    int                        errors;
    int                        checks;
    bit                        timed_out;

    clk_rst_gen cg0 (
        .clk (clk),
        .rst (rst)
    );

    global_mem_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .core_req      (core_req),
        .core_busy     (core_busy),
        .core_ack      (core_ack),
        .core_rd_data  (core_rd_data),
        .host_req      (host_req),
        .host_rd_data  (host_rd_data),
        .host_rd_valid (host_rd_valid)
    );

    // byte address to word, wrapping modulo depth
    function automatic int word_index(input logic [`GM_ADDR_WIDTH-1:0] a);
        return int'((a >> 2) % `GM_MEM_WORDS);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // append one entry, the reference model follows the memory rules
    task automatic add_entry(input logic [2:0] kind, input logic [31:0] addr,
                             input logic [31:0] data, input logic [31:0] alt);
        entry_t e;
        e = {kind, addr, data, alt, 32'd0};
        case (kind)
            K_SET: mptr = addr;
            K_LOAD: begin
                model[word_index(mptr)] = data;
                mptr = mptr + 4;
            end
            K_HREAD: begin
                e.exp = model[word_index(mptr)];
                mptr = mptr + 4;
            end
            K_CWR: model[word_index(addr)] = data;
            K_COLL: begin
                // host first, core data overrides on the same word
                model[word_index(mptr)] = alt;
                model[word_index(addr)] = data;
                mptr = mptr + 4;
            end
            // read kinds, the write issued while busy is dropped
            default: e.exp = model[word_index(addr)];
        endcase
        tbl.push_back(e);
    endtask

    task automatic build_table();
        // stream eight random words in at 0x40, read them back in order
        add_entry(K_SET, 32'h40, '0, '0);
        for (int i = 0; i < 8; i++)
            add_entry(K_LOAD, '0, $random(seed), '0);
        add_entry(K_SET, 32'h40, '0, '0);
        for (int i = 0; i < 8; i++)
            add_entry(K_HREAD, '0, '0, '0);
        // core read latency on loaded words
        add_entry(K_CRD, 32'h48, '0, '0);
        add_entry(K_CRD, 32'h5c, '0, '0);
        // write then read, low bits and a wrapped address alias the same word
        add_entry(K_CWR, 32'h44, $random(seed), '0);
        add_entry(K_CRD, 32'h44, '0, '0);
        add_entry(K_CRD, 32'h47, '0, '0);
        add_entry(K_CRD, 32'h44 + 4 * `GM_MEM_WORDS, '0, '0);
        add_entry(K_CWR, 32'h852, $random(seed), '0);
        add_entry(K_CRD, 32'h50, '0, '0);
        // second request during busy must leave 0x4c alone
        add_entry(K_CBUSY, 32'h4c, '0, $random(seed));
        add_entry(K_CRD, 32'h4c, '0, '0);
        // host and core write 0x58 in the same cycle
        add_entry(K_SET, 32'h58, '0, '0);
        add_entry(K_COLL, 32'h58, $random(seed), $random(seed));
        // full readback through the host port
        add_entry(K_SET, 32'h40, '0, '0);
        for (int i = 0; i < 8; i++)
            add_entry(K_HREAD, '0, '0, '0);
    endtask

    task automatic host_access(input entry_t e);
        int n;
        n = 0;
        case (e.kind)
            K_SET: begin
                host_req.cmd   = host_set_ptr;
                host_req.value = e.addr;
            end
            K_LOAD: begin
                host_req.cmd   = host_load_word;
                host_req.value = e.data;
            end
            default: begin
                host_req.cmd   = host_read_word;
                host_req.value = '0;
            end
        endcase
        @(negedge clk);
        host_req.cmd = host_nop;
        if (e.kind == K_HREAD) begin
            while (host_rd_valid !== 1'b1 && n < WAIT_MAX) begin
                @(negedge clk);
                n++;
            end
            if (host_rd_valid !== 1'b1) begin
                errors++;
                timed_out = 1'b1;
                $display("timeout: host_rd_valid never rose after read_word, t=%0t", $time);
            end else begin
                // valid one cycle after the command edge, then gone
                check_value("host_rd_wait", 0, n);
                check_value("host_rd_data", e.exp, host_rd_data);
                @(negedge clk);
                check_value("host_rd_valid", 0, 32'(host_rd_valid));
                check_value("host_rd_data", 0, host_rd_data);
            end
        end
    endtask

    task automatic core_access(input entry_t e);
        int n;
        int busy_n;
        n         = 0;
        busy_n    = 0;
        core_req.op      = (e.kind == K_CWR || e.kind == K_COLL) ? op_write : op_read;
        core_req.addr    = e.addr;
        core_req.wr_data = e.data;
        @(negedge clk);
        // n counts edges after the sampling edge
        while (core_ack !== 1'b1 && n < WAIT_MAX) begin
            if (n == 0 && e.kind == K_CBUSY) begin
                core_req.op      = op_write;
                core_req.wr_data = e.alt;
            end else begin
                core_req.op = op_none;
            end
            // host load_word shares the cycle of the core write strobe
            if (e.kind == K_COLL && n == `GM_MEM_DELAY) begin
                host_req.cmd   = host_load_word;
                host_req.value = e.alt;
            end else begin
                host_req.cmd = host_nop;
            end
            if (core_busy === 1'b1)
                busy_n++;
            check_value("core_rd_data", 0, core_rd_data);
            @(negedge clk);
            n++;
        end
        host_req.cmd = host_nop;
        if (core_ack !== 1'b1) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: core_ack never rose for address %h, t=%0t", e.addr, $time);
        end else begin
            check_value("core_ack_latency", `GM_MEM_DELAY + 1, n);
            check_value("core_busy_cycles", `GM_MEM_DELAY, busy_n);
            if (e.kind == K_CRD || e.kind == K_CBUSY)
                check_value("core_rd_data", e.exp, core_rd_data);
            else
                check_value("core_rd_data", 0, core_rd_data);
            // exactly one ack, data back to zero
            for (int i = 0; i < `GM_MEM_DELAY + 2; i++) begin
                @(negedge clk);
                check_value("core_ack", 0, 32'(core_ack));
                check_value("core_rd_data", 0, core_rd_data);
            end
        end
    endtask

    initial begin
        int n;
        core_req  = '0;
        host_req  = '0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        mptr      = '0;
        seed      = 99;
        build_table();
        n = 0;
        while (rst !== 1'b1 && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b1) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end else begin
            @(negedge clk);
            check_value("core_busy", 0, 32'(core_busy));
            check_value("core_ack", 0, 32'(core_ack));
            check_value("host_rd_valid", 0, 32'(host_rd_valid));
            check_value("core_rd_data", 0, core_rd_data);
            check_value("host_rd_data", 0, host_rd_data);
        end
        for (int i = 0; i < tbl.size() && !timed_out; i++) begin
            if (tbl[i].kind == K_SET || tbl[i].kind == K_LOAD || tbl[i].kind == K_HREAD)
                host_access(tbl[i]);
            else
                core_access(tbl[i]);
        end
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb/clk_rst_gen.sv
/*
 * testbench clock, 20 ns period, and active low reset for 3 cycles
 */
`timescale 1ns/1ps

module clk_rst_gen (
    output logic clk,
    output logic rst
);

    // free running clock, first rising edge at 10 ns
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // release on a falling edge, half a cycle before the next rising edge
    initial begin
        rst = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst <= 1'b1;
    end

endmodule

// File: src/global_mem_top.sv
/*
 * global memory top: core request controller, word array, host loader port
 */
`timescale 1ns/1ps
`include "gpu_mem_consts.svh"

module global_mem_top
    import core_mem_pkg::*;
    import host_mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  core_req_t                 core_req,
    output logic                      core_busy,
    output logic                      core_ack,
    output logic [`GM_DATA_WIDTH-1:0] core_rd_data,
    input  host_req_t                 host_req,
    output logic [`GM_DATA_WIDTH-1:0] host_rd_data,
    output logic                      host_rd_valid
);

    // controller to array
    array_wr_t                 core_wr;
    logic                      core_rd_en;
    logic [`GM_ADDR_WIDTH-1:0] core_rd_addr;
    logic [`GM_DATA_WIDTH-1:0] core_rd_q;

    // host port to array
    array_wr_t                 host_wr;
    logic                      host_rd_en;
    logic [`GM_ADDR_WIDTH-1:0] host_rd_addr;
    logic [`GM_DATA_WIDTH-1:0] host_rd_q;

    // delayed core access path
    core_req_ctrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .core_req     (core_req),
        .core_busy    (core_busy),
        .core_ack     (core_ack),
        .core_rd_data (core_rd_data),
        .core_wr      (core_wr),
        .core_rd_en   (core_rd_en),
        .core_rd_addr (core_rd_addr),
        .core_rd_q    (core_rd_q)
    );

    mem_word_array array0 (
        .clk          (clk),
        .core_wr      (core_wr),
        .core_rd_en   (core_rd_en),
        .core_rd_addr (core_rd_addr),
        .core_rd_q    (core_rd_q),
        .host_wr      (host_wr),
        .host_rd_en   (host_rd_en),
        .host_rd_addr (host_rd_addr),
        .host_rd_q    (host_rd_q)
    );

    // zero delay loader path
    host_load_port host0 (
        .clk           (clk),
        .rst           (rst),
        .host_req      (host_req),
        .host_rd_data  (host_rd_data),
        .host_rd_valid (host_rd_valid),
        .host_wr       (host_wr),
        .host_rd_en    (host_rd_en),
        .host_rd_addr  (host_rd_addr),
        .host_rd_q     (host_rd_q)
    );

endmodule

// File: src/host_load_port.sv
/*
 * host loader port with auto-incrementing byte pointer
 * set, load-word and read-word commands, no delay
 */
`timescale 1ns/1ps
`include "gpu_mem_consts.svh"

module host_load_port
    import core_mem_pkg::*;
    import host_mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  host_req_t                 host_req,
    output logic [`GM_DATA_WIDTH-1:0] host_rd_data,
    output logic                      host_rd_valid,
    output array_wr_t                 host_wr,
    output logic                      host_rd_en,
    output logic [`GM_ADDR_WIDTH-1:0] host_rd_addr,
    input  logic [`GM_DATA_WIDTH-1:0] host_rd_q
);

    // one word step in bytes
    localparam logic [`GM_ADDR_WIDTH-1:0] PTR_STEP = `GM_ADDR_WIDTH'(4);

    logic [`GM_ADDR_WIDTH-1:0] ptr;
    logic                      rd_valid_q;

    // pointer update
    // both data commands step to the next word
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ptr <= '0;
        end else begin
            case (host_req.cmd)
                host_set_ptr: begin
                    ptr <= `GM_ADDR_WIDTH'(host_req.value);
                end
                host_load_word, host_read_word: begin
                    ptr <= ptr + PTR_STEP;
                end
                default: begin
                    ptr <= ptr;
                end
            endcase
        end
    end

    // readback valid one cycle after the read strobe
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= (host_req.cmd == host_read_word);
        end
    end

    // write lands in the array at the same edge as the command
    assign host_wr.en   = (host_req.cmd == host_load_word);
    assign host_wr.addr = ptr;
    assign host_wr.data = host_req.value;

    // read strobe at the current pointer
    assign host_rd_en   = (host_req.cmd == host_read_word);
    assign host_rd_addr = ptr;

    // Array output is held between reads, so it is masked to zero
    // outside the valid cycle.
    assign host_rd_valid = rd_valid_q;
    assign host_rd_data  = rd_valid_q ? host_rd_q : '0;

endmodule

// File: src/mem_word_array.sv
/*
 * dual port word storage, core and host ports
 * byte address to word index, core write wins on collision
 */
`timescale 1ns/1ps
`include "gpu_mem_consts.svh"

module mem_word_array
    import core_mem_pkg::*;
(
    input  logic                      clk,
    input  array_wr_t                 core_wr,
    input  logic                      core_rd_en,
    input  logic [`GM_ADDR_WIDTH-1:0] core_rd_addr,
    output logic [`GM_DATA_WIDTH-1:0] core_rd_q,
    input  array_wr_t                 host_wr,
    input  logic                      host_rd_en,
    input  logic [`GM_ADDR_WIDTH-1:0] host_rd_addr,
    output logic [`GM_DATA_WIDTH-1:0] host_rd_q
);

    localparam int IDX_W = $clog2(`GM_MEM_WORDS);

    logic [`GM_DATA_WIDTH-1:0] mem [0:`GM_MEM_WORDS-1];

    // drop bits 1:0, upper bits above the index fall away so the index wraps
    function automatic logic [IDX_W-1:0] word_idx(input logic [`GM_ADDR_WIDTH-1:0] byte_addr);
        return byte_addr[IDX_W+1:2];
    endfunction

    logic [IDX_W-1:0] core_wr_idx;
    logic [IDX_W-1:0] host_wr_idx;
    logic [IDX_W-1:0] core_rd_idx;
    logic [IDX_W-1:0] host_rd_idx;

    assign core_wr_idx = word_idx(core_wr.addr);
    assign host_wr_idx = word_idx(host_wr.addr);
    assign core_rd_idx = word_idx(core_rd_addr);
    assign host_rd_idx = word_idx(host_rd_addr);

    // both writers in one process
    // core write comes last so it overrides a host write to the same word
    always_ff @(posedge clk) begin
        if (host_wr.en) begin
            mem[host_wr_idx] <= host_wr.data;
        end
        if (core_wr.en) begin
            mem[core_wr_idx] <= core_wr.data;
        end
    end

    // core read port, data one cycle after the strobe
    always_ff @(posedge clk) begin
        if (core_rd_en) begin
            core_rd_q <= mem[core_rd_idx];
        end
    end

    // host read port, independent of the core port
    always_ff @(posedge clk) begin
        if (host_rd_en) begin
            host_rd_q <= mem[host_rd_idx];
        end
    end

endmodule

// File: src/core_req_ctrl.sv
/*
 * core request controller: accepts one read or write, waits the
 * simulated delay, strobes the word array and acks one cycle later
 */
`timescale 1ns/1ps
`include "gpu_mem_consts.svh"

module core_req_ctrl
    import core_mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  core_req_t                 core_req,
    output logic                      core_busy,
    output logic                      core_ack,
    output logic [`GM_DATA_WIDTH-1:0] core_rd_data,
    output array_wr_t                 core_wr,
    output logic                      core_rd_en,
    output logic [`GM_ADDR_WIDTH-1:0] core_rd_addr,
    input  logic [`GM_DATA_WIDTH-1:0] core_rd_q
);

    // counter wide enough for delay-1, at least one bit
    localparam int CNT_W = ($clog2(`GM_MEM_DELAY) > 0) ? $clog2(`GM_MEM_DELAY) : 1;
    localparam logic [CNT_W-1:0] DELAY_LOAD = CNT_W'(`GM_MEM_DELAY - 1);

    ctrl_state_e               state;
    logic [CNT_W-1:0]          cnt;

    // captured request payload
    logic [`GM_ADDR_WIDTH-1:0] addr_q;
    logic [`GM_DATA_WIDTH-1:0] data_q;

    // array strobes, high for one cycle after the delay expires
    logic                      rd_stb;
    logic                      wr_stb;

    // ack pending for the cycle after a strobe
    logic                      ack_q;
    logic                      ack_rd_q;

    logic                      take;

    // a request is sampled only when idle, op none is no request
    assign take = (state == st_idle) && (core_req.op != op_none);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= st_idle;
            cnt      <= '0;
            rd_stb   <= 1'b0;
            wr_stb   <= 1'b0;
            ack_q    <= 1'b0;
            ack_rd_q <= 1'b0;
        end else begin
            // strobes are single cycle pulses
            rd_stb   <= 1'b0;
            wr_stb   <= 1'b0;
            // ack follows either strobe by one cycle
            ack_q    <= rd_stb | wr_stb;
            ack_rd_q <= rd_stb;

            case (state)
                st_idle: begin
                    case (core_req.op)
                        op_write: begin
                            state <= st_wait_wr;
                            cnt   <= DELAY_LOAD;
                        end
                        op_read: begin
                            state <= st_wait_rd;
                            cnt   <= DELAY_LOAD;
                        end
                        default: begin
                            state <= st_idle;
                        end
                    endcase
                end

                st_wait_rd, st_wait_wr: begin
                    if (cnt == '0) begin
                        // delay done, hit the array and free the port
                        rd_stb <= (state == st_wait_rd);
                        wr_stb <= (state == st_wait_wr);
                        state  <= st_idle;
                    end else begin
                        cnt <= cnt - CNT_W'(1);
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // payload held from sampling until the strobe
    always_ff @(posedge clk) begin
        if (take) begin
            addr_q <= core_req.addr;
            data_q <= core_req.wr_data;
        end
    end

    // busy covers sampling edge up to the strobe edge
    assign core_busy    = (state != st_idle);
    assign core_ack     = ack_q;

    // read word shows only in the ack cycle of a read
    assign core_rd_data = ack_rd_q ? core_rd_q : '0;

    assign core_wr.en   = wr_stb;
    assign core_wr.addr = addr_q;
    assign core_wr.data = data_q;

    assign core_rd_en   = rd_stb;
    assign core_rd_addr = addr_q;

endmodule

// File: src/host_mem_pkg.sv
/*
 * host side types of the global memory
 * loader command enum and host request bundle
 */
`include "gpu_mem_consts.svh"

package host_mem_pkg;

    // loader commands
    // set_ptr loads the byte pointer from value
    // load_word writes value at the pointer, then pointer += 4
    // read_word reads at the pointer, then pointer += 4
    typedef enum logic [1:0] {
        host_nop       = 2'd0,
        host_set_ptr   = 2'd1,
        host_load_word = 2'd2,
        host_read_word = 2'd3
    } host_cmd_e;

    // value is a byte address for set_ptr and the data word for load_word
    // unused by nop and read_word
    typedef struct packed {
        host_cmd_e                 cmd;
        logic [`GM_DATA_WIDTH-1:0] value;
    } host_req_t;

endpackage

// File: src/core_mem_pkg.sv
/*
 * core side types of the global memory
 * operation enum, request bundle, controller states, array write bundle
 */
`include "gpu_mem_consts.svh"

package core_mem_pkg;

    // core operation, none means no request this cycle
    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_read  = 2'd1,
        op_write = 2'd2
    } mem_op_e;

    // single word request from the compute core
    typedef struct packed {
        mem_op_e                   op;
        logic [`GM_ADDR_WIDTH-1:0] addr;
        logic [`GM_DATA_WIDTH-1:0] wr_data;
    } core_req_t;

    // request controller FSM
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_wait_rd = 2'd1,
        st_wait_wr = 2'd2
    } ctrl_state_e;

    // one write into the word array, addr is a byte address
    typedef struct packed {
        logic                      en;
        logic [`GM_ADDR_WIDTH-1:0] addr;
        logic [`GM_DATA_WIDTH-1:0] data;
    } array_wr_t;

endpackage

// File: src/gpu_mem_consts.svh
/*
 * global memory sizing and simulated core access delay
 */
`ifndef GPU_MEM_CONSTS_SVH
`define GPU_MEM_CONSTS_SVH

// byte address width seen by core and host
`define GM_ADDR_WIDTH 32

// one memory word
`define GM_DATA_WIDTH 32

// depth in words, power of two so the word index wraps
`define GM_MEM_WORDS 256

// cycles from request sampling to the array strobe, must be >= 1
`define GM_MEM_DELAY 4

`endif
